/* verilog/exe_pkg.sv */
package exe_pkg;

  localparam int NUM_FU = 5;

  // defaults for the top level parameter list
  localparam int WORD_SIZE_D  = 32;
  localparam int ROB_ENTRY_D  = 16;
  localparam int SB_ENTRY_D   = 8;
  localparam int REG_NUM_D    = 32;
  localparam int MUL_STAGES_D = 3;

  typedef enum logic [4:0] {
    OP_ADD   = 5'd0,
    OP_SUB   = 5'd1,
    OP_SLT   = 5'd2,
    OP_SLTU  = 5'd3,
    OP_AND   = 5'd4,
    OP_OR    = 5'd5,
    OP_XOR   = 5'd6,
    OP_SLL   = 5'd7,
    OP_SRL   = 5'd8,
    OP_SRA   = 5'd9,
    OP_MUL   = 5'd10,
    OP_MULHU = 5'd11,
    OP_BEQ   = 5'd12,
    OP_BNE   = 5'd13,
    OP_BLT   = 5'd14,
    OP_BGE   = 5'd15,
    OP_JAL   = 5'd16,
    OP_LW    = 5'd17,
    OP_SW    = 5'd18
  } exe_op_e;

  // slot of each unit in the valid and result arrays
  typedef enum logic [2:0] {
    FU_ALU    = 3'd0,
    FU_LOGIC  = 3'd1,
    FU_BRANCH = 3'd2,
    FU_MUL    = 3'd3,
    FU_MEM    = 3'd4
  } fu_e;

endpackage

/* verilog/exe_if.sv */
`timescale 1ns/1ns

interface fu_issue_if import exe_pkg::*; #(
  parameter int WORD_SIZE_P = WORD_SIZE_D,
  parameter int ROB_ENTRY_P = ROB_ENTRY_D,
  parameter int REG_NUM_P   = REG_NUM_D
) ();

  exe_op_e                          opcode;
  logic [WORD_SIZE_P-1:0]           operand1;
  // already muxed between immediate and register data
  logic [WORD_SIZE_P-1:0]           operand2;
  logic [WORD_SIZE_P-1:0]           imm;
  logic [WORD_SIZE_P-1:0]           pc;
  logic [$clog2(ROB_ENTRY_P)-1:0]   rob_dest;
  logic [$clog2(REG_NUM_P)-1:0]     reg_dest;

  modport src (output opcode, operand1, operand2, imm, pc, rob_dest, reg_dest);
  modport fu  (input  opcode, operand1, operand2, imm, pc, rob_dest, reg_dest);

endinterface

interface fu_result_if #(
  parameter int WORD_SIZE_P = 32,
  parameter int ROB_ENTRY_P = 16,
  parameter int REG_NUM_P   = 32
) ();

  // one pulse per completion, no back-pressure
  logic                             v;
  logic [$clog2(ROB_ENTRY_P)-1:0]   rob;
  logic [$clog2(REG_NUM_P)-1:0]     reg_dest;
  logic [WORD_SIZE_P-1:0]           value;

  modport fu   (output v, rob, reg_dest, value);
  modport sink (input  v, rob, reg_dest, value);

endinterface

/* verilog/fu_alu.sv */
`timescale 1ns/1ns

module fu_alu import exe_pkg::*; #(
  parameter int WORD_SIZE_P = WORD_SIZE_D,
  parameter int ROB_ENTRY_P = ROB_ENTRY_D,
  parameter int REG_NUM_P   = REG_NUM_D
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       exe_v_i,
  fu_issue_if.fu     iss_i,
  input  logic       mispredict_i,
  fu_result_if.fu    res_o
);

  logic                             v_q;
  logic [$clog2(ROB_ENTRY_P)-1:0]   rob_q;
  logic [$clog2(REG_NUM_P)-1:0]     reg_q;
  logic [WORD_SIZE_P-1:0]           value_d;
  logic [WORD_SIZE_P-1:0]           value_q;

  always_comb begin
    case (iss_i.opcode)
      OP_SUB:  value_d = iss_i.operand1 - iss_i.operand2;
      OP_SLT:  value_d = WORD_SIZE_P'($signed(iss_i.operand1) < $signed(iss_i.operand2));
      OP_SLTU: value_d = WORD_SIZE_P'(iss_i.operand1 < iss_i.operand2);
      default: value_d = iss_i.operand1 + iss_i.operand2;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_q <= 1'b0;
    end else begin
      v_q <= exe_v_i & ~mispredict_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      rob_q   <= iss_i.rob_dest;
      reg_q   <= iss_i.reg_dest;
      value_q <= value_d;
    end
  end

  assign res_o.v        = v_q;
  assign res_o.rob      = rob_q;
  assign res_o.reg_dest = reg_q;
  assign res_o.value    = value_q;

  // scheduler must only route arithmetic ops here
  a_alu_opcode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exe_v_i |-> iss_i.opcode inside {OP_ADD, OP_SUB, OP_SLT, OP_SLTU});

endmodule

/* verilog/fu_logic.sv */
`timescale 1ns/1ns

module fu_logic import exe_pkg::*; #(
  parameter int WORD_SIZE_P = WORD_SIZE_D,
  parameter int ROB_ENTRY_P = ROB_ENTRY_D,
  parameter int REG_NUM_P   = REG_NUM_D
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       exe_v_i,
  fu_issue_if.fu     iss_i,
  input  logic       mispredict_i,
  fu_result_if.fu    res_o
);

  logic                             v_q;
  logic [$clog2(ROB_ENTRY_P)-1:0]   rob_q;
  logic [$clog2(REG_NUM_P)-1:0]     reg_q;
  logic [WORD_SIZE_P-1:0]           value_d;
  logic [WORD_SIZE_P-1:0]           value_q;
  logic [4:0]                       shamt;

  assign shamt = iss_i.operand2[4:0];

  always_comb begin
    case (iss_i.opcode)
      OP_OR:   value_d = iss_i.operand1 | iss_i.operand2;
      OP_XOR:  value_d = iss_i.operand1 ^ iss_i.operand2;
      OP_SLL:  value_d = iss_i.operand1 << shamt;
      OP_SRL:  value_d = iss_i.operand1 >> shamt;
      OP_SRA:  value_d = $signed(iss_i.operand1) >>> shamt;
      default: value_d = iss_i.operand1 & iss_i.operand2;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_q <= 1'b0;
    end else begin
      v_q <= exe_v_i & ~mispredict_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      rob_q   <= iss_i.rob_dest;
      reg_q   <= iss_i.reg_dest;
      value_q <= value_d;
    end
  end

  assign res_o.v        = v_q;
  assign res_o.rob      = rob_q;
  assign res_o.reg_dest = reg_q;
  assign res_o.value    = value_q;

endmodule

/* verilog/fu_branch.sv */
`timescale 1ns/1ns

module fu_branch import exe_pkg::*; #(
  parameter int WORD_SIZE_P = WORD_SIZE_D,
  parameter int ROB_ENTRY_P = ROB_ENTRY_D,
  parameter int REG_NUM_P   = REG_NUM_D
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    exe_v_i,
  fu_issue_if.fu                  iss_i,
  input  logic                    mispredict_i,
  fu_result_if.fu                 res_o,
  output logic                    taken_o,
  output logic [WORD_SIZE_P-1:0]  target_o
);

  logic                             v_q;
  logic                             taken_q;
  logic                             taken_d;
  logic [$clog2(ROB_ENTRY_P)-1:0]   rob_q;
  logic [$clog2(REG_NUM_P)-1:0]     reg_q;
  logic [WORD_SIZE_P-1:0]           value_d;
  logic [WORD_SIZE_P-1:0]           value_q;
  logic [WORD_SIZE_P-1:0]           target_q;

  always_comb begin
    taken_d = 1'b0;
    value_d = '0;
    case (iss_i.opcode)
      OP_BEQ: taken_d = (iss_i.operand1 == iss_i.operand2);
      OP_BNE: taken_d = (iss_i.operand1 != iss_i.operand2);
      OP_BLT: taken_d = ($signed(iss_i.operand1) < $signed(iss_i.operand2));
      OP_BGE: taken_d = ($signed(iss_i.operand1) >= $signed(iss_i.operand2));
      OP_JAL: begin
        // link value is the return address
        taken_d = 1'b1;
        value_d = iss_i.pc + WORD_SIZE_P'(4);
      end
      default: taken_d = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_q     <= 1'b0;
      taken_q <= 1'b0;
    end else begin
      v_q     <= exe_v_i & ~mispredict_i;
      taken_q <= exe_v_i & ~mispredict_i & taken_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      rob_q    <= iss_i.rob_dest;
      reg_q    <= iss_i.reg_dest;
      value_q  <= value_d;
      target_q <= iss_i.pc + iss_i.imm;
    end
  end

  assign res_o.v        = v_q;
  assign res_o.rob      = rob_q;
  assign res_o.reg_dest = reg_q;
  assign res_o.value    = value_q;
  assign taken_o        = taken_q;
  assign target_o       = target_q;

endmodule

/* verilog/fu_mult.sv */
`timescale 1ns/1ns

module fu_mult import exe_pkg::*; #(
  parameter int WORD_SIZE_P  = WORD_SIZE_D,
  parameter int ROB_ENTRY_P  = ROB_ENTRY_D,
  parameter int REG_NUM_P    = REG_NUM_D,
  parameter int MUL_STAGES_P = MUL_STAGES_D
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       exe_v_i,
  fu_issue_if.fu     iss_i,
  input  logic       mispredict_i,
  fu_result_if.fu    res_o
);

  localparam int PW   = 2 * WORD_SIZE_P;
  localparam int LAST = MUL_STAGES_P - 1;

  logic [MUL_STAGES_P-1:0]          v_q;
  logic [MUL_STAGES_P-1:0]          hi_q;
  logic [$clog2(ROB_ENTRY_P)-1:0]   rob_q [MUL_STAGES_P];
  logic [$clog2(REG_NUM_P)-1:0]     reg_q [MUL_STAGES_P];
  logic [PW-1:0]                    prod_q [MUL_STAGES_P];
  logic [PW-1:0]                    prod_d;

  // full unsigned product, low half is the same for signed operands
  assign prod_d = PW'(iss_i.operand1) * PW'(iss_i.operand2);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_q <= '0;
    end else if (mispredict_i) begin
      v_q <= '0;
    end else begin
      v_q[0] <= exe_v_i;
      for (int i = 1; i < MUL_STAGES_P; i++) begin
        v_q[i] <= v_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      hi_q[0]   <= (iss_i.opcode == OP_MULHU);
      rob_q[0]  <= iss_i.rob_dest;
      reg_q[0]  <= iss_i.reg_dest;
      prod_q[0] <= prod_d;
    end
    for (int i = 1; i < MUL_STAGES_P; i++) begin
      hi_q[i]   <= hi_q[i-1];
      rob_q[i]  <= rob_q[i-1];
      reg_q[i]  <= reg_q[i-1];
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign res_o.v        = v_q[LAST];
  assign res_o.rob      = rob_q[LAST];
  assign res_o.reg_dest = reg_q[LAST];
  assign res_o.value    = hi_q[LAST] ? prod_q[LAST][PW-1:WORD_SIZE_P]
                                     : prod_q[LAST][WORD_SIZE_P-1:0];

endmodule

/* verilog/fu_lsu.sv */
`timescale 1ns/1ns

module fu_lsu import exe_pkg::*; #(
  parameter int  WORD_SIZE_P = WORD_SIZE_D,
  parameter int  ROB_ENTRY_P = ROB_ENTRY_D,
  parameter int  SB_ENTRY_P  = SB_ENTRY_D,
  parameter int  REG_NUM_P   = REG_NUM_D,
  localparam int ROB_W       = $clog2(ROB_ENTRY_P),
  localparam int SB_W        = $clog2(SB_ENTRY_P),
  localparam int REG_W       = $clog2(REG_NUM_P)
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    exe_v_i,
  fu_issue_if.fu                  iss_i,
  input  logic [WORD_SIZE_P-1:0]  src2_i,
  input  logic [SB_W-1:0]         sb_dest_i,
  input  logic                    mispredict_i,
  fu_result_if.fu                 res_o,
  output logic                    lsu_sb_v_o,
  output logic [ROB_W-1:0]        lsu_sb_rob_o,
  output logic [SB_W-1:0]         lsu_sb_num_o,
  output logic [WORD_SIZE_P-1:0]  lsu_sb_addr_o,
  output logic [WORD_SIZE_P-1:0]  lsu_sb_data_o,
  output logic [WORD_SIZE_P-1:0]  exe_ld_bypass_addr_o,
  output logic [SB_W-1:0]         exe_ld_bypass_sb_num_o,
  input  logic                    sb_ld_bypass_valid_i,
  input  logic [WORD_SIZE_P-1:0]  sb_ld_bypass_value_i,
  output logic                    lsu_rd_o,
  output logic [WORD_SIZE_P-1:0]  lsu_addr_o,
  input  logic [WORD_SIZE_P-1:0]  mem_data_i
);

  // stage 1
  logic                    st_v_q;
  logic                    ld_v_q;
  logic [WORD_SIZE_P-1:0]  addr_q;
  logic [WORD_SIZE_P-1:0]  data_q;
  logic [ROB_W-1:0]        rob_q;
  logic [REG_W-1:0]        reg_q;
  logic [SB_W-1:0]         sb_q;
  // stage 2, loads only
  logic                    ld2_v_q;
  logic [ROB_W-1:0]        ld2_rob_q;
  logic [REG_W-1:0]        ld2_reg_q;
  logic [WORD_SIZE_P-1:0]  ld2_value_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      st_v_q  <= 1'b0;
      ld_v_q  <= 1'b0;
      ld2_v_q <= 1'b0;
    end else begin
      st_v_q  <= exe_v_i & ~mispredict_i & (iss_i.opcode == OP_SW);
      ld_v_q  <= exe_v_i & ~mispredict_i & (iss_i.opcode == OP_LW);
      ld2_v_q <= ld_v_q & ~mispredict_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      addr_q <= iss_i.operand1 + iss_i.imm;
      data_q <= src2_i;
      rob_q  <= iss_i.rob_dest;
      reg_q  <= iss_i.reg_dest;
      sb_q   <= sb_dest_i;
    end
    if (ld_v_q) begin
      ld2_rob_q   <= rob_q;
      ld2_reg_q   <= reg_q;
      // younger store in the buffer wins over memory
      ld2_value_q <= sb_ld_bypass_valid_i ? sb_ld_bypass_value_i : mem_data_i;
    end
  end

  assign lsu_sb_v_o    = st_v_q;
  assign lsu_sb_rob_o  = rob_q;
  assign lsu_sb_num_o  = sb_q;
  assign lsu_sb_addr_o = addr_q;
  assign lsu_sb_data_o = data_q;

  assign lsu_rd_o               = ld_v_q;
  assign lsu_addr_o             = addr_q;
  assign exe_ld_bypass_addr_o   = addr_q;
  assign exe_ld_bypass_sb_num_o = sb_q;

  assign res_o.v        = st_v_q | ld2_v_q;
  assign res_o.rob      = ld2_v_q ? ld2_rob_q : rob_q;
  assign res_o.reg_dest = ld2_v_q ? ld2_reg_q : reg_q;
  assign res_o.value    = ld2_v_q ? ld2_value_q : '0;

  a_strobe_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown({lsu_sb_v_o, lsu_rd_o}));

  // a store issued right behind a load would collide on the result port
  a_no_result_clash: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(st_v_q && ld2_v_q));

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import exe_pkg::*; #(
  parameter int  WORD_SIZE_P  = WORD_SIZE_D,
  parameter int  ROB_ENTRY_P  = ROB_ENTRY_D,
  parameter int  SB_ENTRY_P   = SB_ENTRY_D,
  parameter int  REG_NUM_P    = REG_NUM_D,
  parameter int  MUL_STAGES_P = MUL_STAGES_D,
  localparam int ROB_W        = $clog2(ROB_ENTRY_P),
  localparam int SB_W         = $clog2(SB_ENTRY_P),
  localparam int REG_W        = $clog2(REG_NUM_P)
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // issue bus
  input  logic [NUM_FU-1:0]                   issue_v_i,
  input  exe_op_e                             issue_opcode_i,
  input  logic [WORD_SIZE_P-1:0]              issue_src1_i,
  input  logic [WORD_SIZE_P-1:0]              issue_src2_i,
  input  logic [WORD_SIZE_P-1:0]              issue_imm_i,
  input  logic                                issue_use_imm_i,
  input  logic [WORD_SIZE_P-1:0]              issue_pc_i,
  input  logic [ROB_W-1:0]                    issue_rob_dest_i,
  input  logic [REG_W-1:0]                    issue_reg_dest_i,
  input  logic [SB_W-1:0]                     issue_sb_dest_i,
  // results, indexed by fu_e
  output logic [NUM_FU-1:0]                   res_v_o,
  output logic [NUM_FU-1:0][ROB_W-1:0]        res_rob_o,
  output logic [NUM_FU-1:0][REG_W-1:0]        res_reg_o,
  output logic [NUM_FU-1:0][WORD_SIZE_P-1:0]  res_value_o,
  output logic                                br_taken_o,
  output logic [WORD_SIZE_P-1:0]              br_target_o,
  // store buffer
  output logic                                lsu_sb_v_o,
  output logic [ROB_W-1:0]                    lsu_sb_rob_o,
  output logic [SB_W-1:0]                     lsu_sb_num_o,
  output logic [WORD_SIZE_P-1:0]              lsu_sb_addr_o,
  output logic [WORD_SIZE_P-1:0]              lsu_sb_data_o,
  output logic [WORD_SIZE_P-1:0]              exe_ld_bypass_addr_o,
  output logic [SB_W-1:0]                     exe_ld_bypass_sb_num_o,
  input  logic                                sb_ld_bypass_valid_i,
  input  logic [WORD_SIZE_P-1:0]              sb_ld_bypass_value_i,
  // memory
  output logic                                lsu_rd_o,
  output logic [WORD_SIZE_P-1:0]              lsu_addr_o,
  input  logic [WORD_SIZE_P-1:0]              mem_data_i,
  input  logic                                mispredict_i
);

  fu_issue_if #(
    .WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY_P(ROB_ENTRY_P), .REG_NUM_P(REG_NUM_P)
  ) iss_if ();

  fu_result_if #(
    .WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY_P(ROB_ENTRY_P), .REG_NUM_P(REG_NUM_P)
  ) res_if [NUM_FU] ();

  assign iss_if.opcode   = issue_opcode_i;
  assign iss_if.operand1 = issue_src1_i;
  assign iss_if.operand2 = issue_use_imm_i ? issue_imm_i : issue_src2_i;
  assign iss_if.imm      = issue_imm_i;
  assign iss_if.pc       = issue_pc_i;
  assign iss_if.rob_dest = issue_rob_dest_i;
  assign iss_if.reg_dest = issue_reg_dest_i;

  fu_alu #(
    .WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY_P(ROB_ENTRY_P), .REG_NUM_P(REG_NUM_P)
  ) u_alu (
    .clk_i, .arst_n_i, .exe_v_i(issue_v_i[FU_ALU]), .iss_i(iss_if),
    .mispredict_i, .res_o(res_if[FU_ALU])
  );

  fu_logic #(
    .WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY_P(ROB_ENTRY_P), .REG_NUM_P(REG_NUM_P)
  ) u_logic (
    .clk_i, .arst_n_i, .exe_v_i(issue_v_i[FU_LOGIC]), .iss_i(iss_if),
    .mispredict_i, .res_o(res_if[FU_LOGIC])
  );

  fu_branch #(
    .WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY_P(ROB_ENTRY_P), .REG_NUM_P(REG_NUM_P)
  ) u_branch (
    .clk_i, .arst_n_i, .exe_v_i(issue_v_i[FU_BRANCH]), .iss_i(iss_if),
    .mispredict_i, .res_o(res_if[FU_BRANCH]),
    .taken_o(br_taken_o), .target_o(br_target_o)
  );

  fu_mult #(
    .WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY_P(ROB_ENTRY_P), .REG_NUM_P(REG_NUM_P),
    .MUL_STAGES_P(MUL_STAGES_P)
  ) u_mult (
    .clk_i, .arst_n_i, .exe_v_i(issue_v_i[FU_MUL]), .iss_i(iss_if),
    .mispredict_i, .res_o(res_if[FU_MUL])
  );

  // store data is always the register operand
  fu_lsu #(
    .WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY_P(ROB_ENTRY_P), .SB_ENTRY_P(SB_ENTRY_P),
    .REG_NUM_P(REG_NUM_P)
  ) u_lsu (
    .clk_i, .arst_n_i, .exe_v_i(issue_v_i[FU_MEM]), .iss_i(iss_if),
    .src2_i(issue_src2_i), .sb_dest_i(issue_sb_dest_i), .mispredict_i,
    .res_o(res_if[FU_MEM]),
    .lsu_sb_v_o, .lsu_sb_rob_o, .lsu_sb_num_o, .lsu_sb_addr_o, .lsu_sb_data_o,
    .exe_ld_bypass_addr_o, .exe_ld_bypass_sb_num_o,
    .sb_ld_bypass_valid_i, .sb_ld_bypass_value_i,
    .lsu_rd_o, .lsu_addr_o, .mem_data_i
  );

  for (genvar i = 0; i < NUM_FU; i++) begin : g_res
    assign res_v_o[i]     = res_if[i].v;
    assign res_rob_o[i]   = res_if[i].rob;
    assign res_reg_o[i]   = res_if[i].reg_dest;
    assign res_value_o[i] = res_if[i].value;
  end

  // single issue bus, one unit per cycle
  a_issue_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(issue_v_i));

endmodule

/* sim/exe_tb_tasks.svh */
task automatic fail_run();
  $display("TB FAILED");
  $fatal(1, "simulation stopped at first error");
endtask

task automatic check_value(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
  assert (got === exp) else begin
    $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
    fail_run();
  end
endtask

task automatic check_quiet(input string when);
  assert (res_v === '0 && lsu_rd === 1'b0 && lsu_sb_v === 1'b0) else begin
    $display("** Error @ %0t ns: activity %s, res_v=%b lsu_rd=%b lsu_sb_v=%b",
             $time, when, res_v, lsu_rd, lsu_sb_v);
    fail_run();
  end
endtask

function automatic logic [31:0] rand_word();
  return $random(seed);
endfunction

function automatic logic [31:0] arith_ref(input exe_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
  logic [31:0] r;
  case (op)
    OP_ADD:  r = a + b;
    OP_SUB:  r = a - b;
    OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
    OP_AND:  r = a & b;
    OP_OR:   r = a | b;
    OP_XOR:  r = a ^ b;
    OP_SLL:  r = a << b[4:0];
    OP_SRL:  r = a >> b[4:0];
    OP_SRA:  r = $unsigned($signed(a) >>> b[4:0]);
    default: r = 'x;
  endcase
  return r;
endfunction

function automatic logic branch_ref(input exe_op_e op, input logic [31:0] a,
                                    input logic [31:0] b);
  case (op)
    OP_BEQ:  return a == b;
    OP_BNE:  return a != b;
    OP_BLT:  return $signed(a) < $signed(b);
    OP_BGE:  return $signed(a) >= $signed(b);
    default: return 1'b1;
  endcase
endfunction

function automatic logic [31:0] product_ref(input exe_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
  logic [63:0] p;
  p = {32'd0, a} * {32'd0, b};
  return (op == OP_MULHU) ? p[63:32] : p[31:0];
endfunction

// smp is the edge count of the driving edge
// latencies count from there
task automatic drive_issue(input fu_e unit, input exe_op_e op, input logic [31:0] src1,
                           input logic [31:0] src2, input logic [31:0] imm,
                           input logic use_imm, input logic [31:0] pc,
                           input logic [ROB_W-1:0] rob, input logic [REG_W-1:0] rdst,
                           input logic [SB_W-1:0] sb, output int smp);
  @(posedge clk);
  smp           = cycle_cnt + 1;
  issue_v       <= NUM_FU'(1) << unit;
  issue_opcode  <= op;
  issue_src1    <= src1;
  issue_src2    <= src2;
  issue_imm     <= imm;
  issue_use_imm <= use_imm;
  issue_pc      <= pc;
  issue_rob     <= rob;
  issue_reg     <= rdst;
  issue_sb      <= sb;
endtask

task automatic drive_idle();
  @(posedge clk);
  issue_v <= '0;
endtask

task automatic wait_unit(input fu_e unit, output int at);
  int n;
  n  = 0;
  at = -1;
  while (at < 0 && n < TIMEOUT) begin
    @(negedge clk);
    n++;
    if (res_v[unit] === 1'b1) at = cycle_cnt;
  end
  if (at < 0) begin
    $display("timeout: unit %0d gave no result within %0d cycles", unit, TIMEOUT);
    fail_run();
  end
endtask

task automatic expect_result(input fu_e unit, input int smp, input int lat,
                             input logic [ROB_W-1:0] rob, input logic [REG_W-1:0] rdst,
                             input logic [31:0] value);
  int at;
  wait_unit(unit, at);
  check_value("result latency", 32'(at - smp), 32'(lat));
  check_value("result rob tag", 32'(res_rob[unit]), 32'(rob));
  check_value("result reg tag", 32'(res_reg[unit]), 32'(rdst));
  check_value("result value", res_value[unit], value);
endtask

task automatic arith_logic_ops();
  exe_op_e ops [10] = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND,
                        OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
  logic [31:0]      a;
  logic [31:0]      b;
  logic [31:0]      imm;
  logic             use_imm;
  logic [ROB_W-1:0] rob;
  logic [REG_W-1:0] rdst;
  fu_e              unit;
  int               smp;
  for (int k = 0; k < 10; k++) begin
    unit = (k < 4) ? FU_ALU : FU_LOGIC;
    for (int r = 0; r < 4; r++) begin
      a       = rand_word();
      b       = rand_word();
      imm     = rand_word();
      use_imm = r[0];
      rob     = ROB_W'(rand_word());
      rdst    = REG_W'(rand_word());
      drive_issue(unit, ops[k], a, b, imm, use_imm, 32'h0, rob, rdst, '0, smp);
      drive_idle();
      expect_result(unit, smp, 1, rob, rdst, arith_ref(ops[k], a, use_imm ? imm : b));
    end
  end
endtask

task automatic branch_ops();
  exe_op_e ops [5] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL};
  logic [31:0]      a;
  logic [31:0]      b;
  logic [31:0]      pc;
  logic [31:0]      imm;
  logic [ROB_W-1:0] rob;
  logic [REG_W-1:0] rdst;
  int               smp;
  for (int k = 0; k < 5; k++) begin
    for (int r = 0; r < 4; r++) begin
      a    = rand_word();
      // every other case compares equal operands
      b    = r[0] ? a : rand_word();
      pc   = rand_word() & 32'hFFFF_FFFC;
      imm  = rand_word() & 32'hFFFF_FFFE;
      rob  = ROB_W'(rand_word());
      rdst = REG_W'(rand_word());
      drive_issue(FU_BRANCH, ops[k], a, b, imm, 1'b0, pc, rob, rdst, '0, smp);
      drive_idle();
      expect_result(FU_BRANCH, smp, 1, rob, rdst, (ops[k] == OP_JAL) ? pc + 32'd4 : 32'd0);
      check_value("branch taken", 32'(br_taken), 32'(branch_ref(ops[k], a, b)));
      check_value("branch target", br_target, pc + imm);
    end
  end
endtask

// burst length equals the depth, so the first result lands right after the idle edge
task automatic mul_back_to_back();
  exe_op_e          ops [MUL_STAGES];
  logic [31:0]      a [MUL_STAGES];
  logic [31:0]      b [MUL_STAGES];
  logic [ROB_W-1:0] rob [MUL_STAGES];
  logic [REG_W-1:0] rdst [MUL_STAGES];
  int               smp [MUL_STAGES];
  for (int pass = 0; pass < 2; pass++) begin
    for (int j = 0; j < MUL_STAGES; j++) begin
      ops[j]  = ((j + pass) % 2 == 1) ? OP_MULHU : OP_MUL;
      a[j]    = rand_word();
      b[j]    = rand_word();
      rob[j]  = ROB_W'(rand_word());
      rdst[j] = REG_W'(rand_word());
      drive_issue(FU_MUL, ops[j], a[j], b[j], 32'h0, 1'b0, 32'h0, rob[j], rdst[j], '0,
                  smp[j]);
    end
    drive_idle();
    for (int j = 0; j < MUL_STAGES; j++) begin
      expect_result(FU_MUL, smp[j], MUL_STAGES, rob[j], rdst[j],
                    product_ref(ops[j], a[j], b[j]));
    end
  end
endtask

task automatic store_to_buffer(output logic [31:0] addr, output logic [31:0] data);
  logic [31:0]      base;
  logic [31:0]      imm;
  logic [ROB_W-1:0] rob;
  int               smp;
  int               at;
  base = 32'h0000_0100;
  imm  = rand_word() & 32'h0000_00FC;
  data = rand_word();
  rob  = ROB_W'(rand_word());
  addr = base + imm;
  drive_issue(FU_MEM, OP_SW, base, data, imm, 1'b1, 32'h0, rob, '0, SB_W'(ST_ENTRY), smp);
  drive_idle();
  wait_unit(FU_MEM, at);
  check_value("store latency", 32'(at - smp), 32'd1);
  check_value("store buffer strobe", 32'(lsu_sb_v), 32'd1);
  check_value("store address", lsu_sb_addr, addr);
  check_value("store data", lsu_sb_data, data);
  check_value("store buffer entry", 32'(lsu_sb_num), 32'(ST_ENTRY));
  check_value("store rob tag", 32'(lsu_sb_rob), 32'(rob));
  check_value("store completion tag", 32'(res_rob[FU_MEM]), 32'(rob));
  check_value("store completion value", res_value[FU_MEM], 32'd0);
endtask

task automatic load_once(input logic [31:0] src1, input logic [31:0] imm,
                         input logic [SB_W-1:0] sb, input logic [31:0] exp);
  logic [ROB_W-1:0] rob;
  logic [REG_W-1:0] rdst;
  int               smp;
  rob  = ROB_W'(rand_word());
  rdst = REG_W'(rand_word());
  drive_issue(FU_MEM, OP_LW, src1, 32'h0, imm, 1'b1, 32'h0, rob, rdst, sb, smp);
  drive_idle();
  // stage 1 reads memory and asks the store buffer
  @(negedge clk);
  check_value("load read strobe", 32'(lsu_rd), 32'd1);
  check_value("load memory address", lsu_addr, src1 + imm);
  check_value("load bypass address", ld_bypass_addr, src1 + imm);
  check_value("load bypass entry", 32'(ld_bypass_sb_num), 32'(sb));
  check_value("early load result", 32'(res_v[FU_MEM]), 32'd0);
  expect_result(FU_MEM, smp, 2, rob, rdst, exp);
endtask

task automatic load_from_mem(input logic [31:0] st_addr, input logic [31:0] st_data);
  logic [31:0] la;
  la = st_addr + 32'h40;
  // entry holds another address
  load_once(la - 32'h8, 32'h8, SB_W'(ST_ENTRY), mem_words[la[9:2]]);
  // entry never written
  load_once(st_addr, 32'h0, SB_W'(ST_ENTRY + 2), mem_words[st_addr[9:2]]);
  load_once(st_addr - 32'h10, 32'h10, SB_W'(ST_ENTRY), st_data);
endtask

task automatic mispredict_flush();
  logic [31:0]      a;
  logic [31:0]      b;
  logic [ROB_W-1:0] rob;
  logic [REG_W-1:0] rdst;
  int               smp;
  drive_issue(FU_MUL, OP_MUL, rand_word(), rand_word(), 32'h0, 1'b0, 32'h0,
              ROB_W'(1), REG_W'(1), '0, smp);
  drive_issue(FU_MEM, OP_LW, 32'h80, 32'h0, 32'h0, 1'b1, 32'h0,
              ROB_W'(2), REG_W'(2), '0, smp);
  // this issue meets the flush at the same edge
  drive_issue(FU_MUL, OP_MULHU, rand_word(), rand_word(), 32'h0, 1'b0, 32'h0,
              ROB_W'(3), REG_W'(3), '0, smp);
  mispredict <= 1'b1;
  drive_idle();
  mispredict <= 1'b0;
  for (int n = 0; n < MUL_STAGES + 3; n++) begin
    @(negedge clk);
    check_quiet("after mispredict");
  end
  a    = rand_word();
  b    = rand_word();
  rob  = ROB_W'(rand_word());
  rdst = REG_W'(rand_word());
  drive_issue(FU_ALU, OP_ADD, a, b, 32'h0, 1'b0, 32'h0, rob, rdst, '0, smp);
  drive_idle();
  expect_result(FU_ALU, smp, 1, rob, rdst, a + b);
endtask

/* sim/execute_stage_tb.sv */
`timescale 1ns/1ns

module execute_stage_tb import exe_pkg::*; ();

  localparam int WORD_SIZE  = 32;
  localparam int ROB_ENTRY  = 16;
  localparam int SB_ENTRY   = 8;
  localparam int REG_NUM    = 32;
  localparam int MUL_STAGES = 3;
  localparam int ROB_W      = $clog2(ROB_ENTRY);
  localparam int SB_W       = $clog2(SB_ENTRY);
  localparam int REG_W      = $clog2(REG_NUM);
  localparam int TIMEOUT    = 20;
  localparam int ST_ENTRY   = 3;

  logic                               clk;
  logic                               arst_n;
  logic [NUM_FU-1:0]                  issue_v;
  exe_op_e                            issue_opcode;
  logic [31:0]                        issue_src1;
  logic [31:0]                        issue_src2;
  logic [31:0]                        issue_imm;
  logic                               issue_use_imm;
  logic [31:0]                        issue_pc;
  logic [ROB_W-1:0]                   issue_rob;
  logic [REG_W-1:0]                   issue_reg;
  logic [SB_W-1:0]                    issue_sb;
  logic                               mispredict;
  logic [NUM_FU-1:0]                  res_v;
  logic [NUM_FU-1:0][ROB_W-1:0]       res_rob;
  logic [NUM_FU-1:0][REG_W-1:0]       res_reg;
  logic [NUM_FU-1:0][31:0]            res_value;
  logic                               br_taken;
  logic [31:0]                        br_target;
  logic                               lsu_sb_v;
  logic [ROB_W-1:0]                   lsu_sb_rob;
  logic [SB_W-1:0]                    lsu_sb_num;
  logic [31:0]                        lsu_sb_addr;
  logic [31:0]                        lsu_sb_data;
  logic [31:0]                        ld_bypass_addr;
  logic [SB_W-1:0]                    ld_bypass_sb_num;
  logic                               sb_bypass_valid;
  logic [31:0]                        sb_bypass_value;
  logic                               lsu_rd;
  logic [31:0]                        lsu_addr;
  logic [31:0]                        mem_data;

  int     cycle_cnt = 0;
  integer seed = 32'h1166;

  // memory model, 1 KiB of words
  logic [31:0] mem_words [256];
  // store buffer model
  logic        sb_valid [SB_ENTRY];
  logic [31:0] sb_addr [SB_ENTRY];
  logic [31:0] sb_data [SB_ENTRY];
  logic        sb_hit;

  execute_stage #(
    .WORD_SIZE_P(WORD_SIZE), .ROB_ENTRY_P(ROB_ENTRY), .SB_ENTRY_P(SB_ENTRY),
    .REG_NUM_P(REG_NUM), .MUL_STAGES_P(MUL_STAGES)
  ) uut (
    .clk_i(clk), .arst_n_i(arst_n),
    .issue_v_i(issue_v), .issue_opcode_i(issue_opcode),
    .issue_src1_i(issue_src1), .issue_src2_i(issue_src2), .issue_imm_i(issue_imm),
    .issue_use_imm_i(issue_use_imm), .issue_pc_i(issue_pc),
    .issue_rob_dest_i(issue_rob), .issue_reg_dest_i(issue_reg),
    .issue_sb_dest_i(issue_sb),
    .res_v_o(res_v), .res_rob_o(res_rob), .res_reg_o(res_reg), .res_value_o(res_value),
    .br_taken_o(br_taken), .br_target_o(br_target),
    .lsu_sb_v_o(lsu_sb_v), .lsu_sb_rob_o(lsu_sb_rob), .lsu_sb_num_o(lsu_sb_num),
    .lsu_sb_addr_o(lsu_sb_addr), .lsu_sb_data_o(lsu_sb_data),
    .exe_ld_bypass_addr_o(ld_bypass_addr), .exe_ld_bypass_sb_num_o(ld_bypass_sb_num),
    .sb_ld_bypass_valid_i(sb_bypass_valid), .sb_ld_bypass_value_i(sb_bypass_value),
    .lsu_rd_o(lsu_rd), .lsu_addr_o(lsu_addr), .mem_data_i(mem_data),
    .mispredict_i(mispredict)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem_words[i] = 32'hBE00_0000 ^ (i << 2) ^ (i << 18);
    end
  end

  assign mem_data = (lsu_rd === 1'b1 && lsu_addr[31:10] == '0) ? mem_words[lsu_addr[9:2]]
                                                                 : '0;

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < SB_ENTRY; i++) begin
        sb_valid[i] <= 1'b0;
      end
    end else if (lsu_sb_v === 1'b1) begin
      sb_valid[lsu_sb_num] <= 1'b1;
      sb_addr[lsu_sb_num]  <= lsu_sb_addr;
      sb_data[lsu_sb_num]  <= lsu_sb_data;
    end
  end

  // hit only when the named entry holds the same address
  assign sb_hit = (lsu_rd === 1'b1) && (sb_valid[ld_bypass_sb_num] === 1'b1) &&
                  (sb_addr[ld_bypass_sb_num] == ld_bypass_addr);
  assign sb_bypass_valid = sb_hit;
  assign sb_bypass_value = sb_hit ? sb_data[ld_bypass_sb_num] : '0;

  `include "exe_tb_tasks.svh"

  initial begin
    logic [31:0] st_addr;
    logic [31:0] st_data;
    arst_n        <= 1'b0;
    issue_v       <= '0;
    issue_opcode  <= OP_ADD;
    issue_src1    <= '0;
    issue_src2    <= '0;
    issue_imm     <= '0;
    issue_use_imm <= 1'b0;
    issue_pc      <= '0;
    issue_rob     <= '0;
    issue_reg     <= '0;
    issue_sb      <= '0;
    mispredict    <= 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_quiet("after reset");

    arith_logic_ops();
    branch_ops();
    mul_back_to_back();
    store_to_buffer(st_addr, st_data);
    load_from_mem(st_addr, st_data);
    mispredict_flush();

    $display("TB PASSED");
    $finish;
  end

endmodule

/* execute_stage.f */
verilog/exe_pkg.sv
verilog/exe_if.sv
verilog/fu_alu.sv
verilog/fu_logic.sv
verilog/fu_branch.sv
verilog/fu_mult.sv
verilog/fu_lsu.sv
verilog/execute_stage.sv
+incdir+sim
sim/execute_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= execute_stage_tb
RTL_TOP   ?= execute_stage
FILELIST  ?= execute_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)
